// ==== Bender.yml ====
package:
  name: selen_exe

sources:
  - src/core_ctrl_pkg.sv
  - src/core_byp_pkg.sv
  - src/core_exe_operand.sv
  - src/core_alu.sv
  - src/core_exe_reg.sv
  - src/core_exe_s.sv
  - target: test
    files:
      - testbench/tb_core_exe_s.sv

// ==== selen_exe.f ====
src/core_ctrl_pkg.sv
src/core_byp_pkg.sv
src/core_exe_operand.sv
src/core_alu.sv
src/core_exe_reg.sv
src/core_exe_s.sv
testbench/tb_core_exe_s.sv

// ==== src/core_alu.sv ====
// rv32i alu: arithmetic, logic, shifts, compares and branch condition evaluation
module core_alu (
	input  logic [31:0]                        alu_a,
	input  logic [31:0]                        alu_b,
	input  logic [core_ctrl_pkg::alu_op_w-1:0] alu_op,
	input  logic [core_ctrl_pkg::cnd_w-1:0]    alu_cnd,
	output logic [31:0]                        alu_result,
	output logic                               branch_taken
);

	// shift amount is the low five bits of b
	logic [4:0]  shamt;
	// comparators, shared by slt/sltu and branches
	logic        a_eq_b;
	logic        a_lt_b_s;
	logic        a_lt_b_u;
	// adder and subtractor outputs
	logic [31:0] sum;
	logic [31:0] diff;

	assign shamt    = alu_b[4:0];
	assign sum      = alu_a + alu_b;
	assign diff     = alu_a - alu_b;
	assign a_eq_b   = (alu_a == alu_b);
	assign a_lt_b_s = ($signed(alu_a) < $signed(alu_b));
	assign a_lt_b_u = (alu_a < alu_b);

	// --------------------
	// result
	// --------------------
	always_comb begin
		case (alu_op)
			core_ctrl_pkg::alu_add:    alu_result = sum;
			core_ctrl_pkg::alu_sub:    alu_result = diff;
			core_ctrl_pkg::alu_sll:    alu_result = alu_a << shamt;
			// compares give 0 or 1
			core_ctrl_pkg::alu_slt:    alu_result = {31'd0, a_lt_b_s};
			core_ctrl_pkg::alu_sltu:   alu_result = {31'd0, a_lt_b_u};
			core_ctrl_pkg::alu_xor:    alu_result = alu_a ^ alu_b;
			core_ctrl_pkg::alu_srl:    alu_result = alu_a >> shamt;
			// arithmetic shift keeps the sign
			core_ctrl_pkg::alu_sra:    alu_result = $unsigned($signed(alu_a) >>> shamt);
			core_ctrl_pkg::alu_or:     alu_result = alu_a | alu_b;
			core_ctrl_pkg::alu_and:    alu_result = alu_a & alu_b;
			// lui path
			core_ctrl_pkg::alu_pass_b: alu_result = alu_b;
			default:                   alu_result = 32'd0;
		endcase
	end

	// --------------------
	// branch decision
	// --------------------
	always_comb begin
		case (alu_cnd)
			core_ctrl_pkg::cnd_never:  branch_taken = 1'b0;
			// jal / jalr
			core_ctrl_pkg::cnd_always: branch_taken = 1'b1;
			core_ctrl_pkg::cnd_eq:     branch_taken = a_eq_b;
			core_ctrl_pkg::cnd_ne:     branch_taken = !a_eq_b;
			core_ctrl_pkg::cnd_lt:     branch_taken = a_lt_b_s;
			core_ctrl_pkg::cnd_ge:     branch_taken = !a_lt_b_s;
			core_ctrl_pkg::cnd_ltu:    branch_taken = a_lt_b_u;
			core_ctrl_pkg::cnd_geu:    branch_taken = !a_lt_b_u;
			default:                   branch_taken = 1'b0;
		endcase
	end

	// codes above alu_pass_b are never issued by decode
	always_comb begin
		assert final ($isunknown(alu_op) || alu_op <= core_ctrl_pkg::alu_pass_b)
			else $error("illegal alu_op %0d", alu_op);
	end

endmodule

// ==== src/core_byp_pkg.sv ====
// bypass select codes, hazard command encodings and register index width
package core_byp_pkg;

	// --------------------
	// bypass selects
	// --------------------
	localparam int byp_w = 2;

	// value read from the register file in decode
	localparam logic [byp_w-1:0] byp_rf  = 2'd0;
	// result sitting in the memory stage
	localparam logic [byp_w-1:0] byp_mem = 2'd1;
	// result sitting in the writeback stage
	localparam logic [byp_w-1:0] byp_wb  = 2'd2;
	// code 3 is illegal

	// --------------------
	// hazard commands
	// --------------------
	localparam int haz_cmd_w = 2;

	// passed through the stage untouched
	localparam logic [haz_cmd_w-1:0] haz_none   = 2'd0;
	localparam logic [haz_cmd_w-1:0] haz_load   = 2'd1;
	localparam logic [haz_cmd_w-1:0] haz_branch = 2'd2;
	localparam logic [haz_cmd_w-1:0] haz_jump   = 2'd3;

	// --------------------
	// register file index
	// --------------------
	// 32 architectural registers
	localparam int reg_idx_w = 5;

endpackage

// ==== src/core_ctrl_pkg.sv ====
// decode-side control encodings: alu ops, branch conditions, mux bus bits, writeback ext codes
package core_ctrl_pkg;

	// --------------------
	// alu operation codes
	// --------------------
	localparam int alu_op_w = 4;

	localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
	localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
	localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
	localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
	localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
	localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
	localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
	// forwards operand b, used for lui
	localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;
	// 11..15 are illegal

	// --------------------
	// branch conditions
	// --------------------
	localparam int cnd_w = 3;

	localparam logic [cnd_w-1:0] cnd_never  = 3'd0;
	localparam logic [cnd_w-1:0] cnd_always = 3'd1;
	localparam logic [cnd_w-1:0] cnd_eq     = 3'd2;
	localparam logic [cnd_w-1:0] cnd_ne     = 3'd3;
	localparam logic [cnd_w-1:0] cnd_lt     = 3'd4;
	localparam logic [cnd_w-1:0] cnd_ge     = 3'd5;
	localparam logic [cnd_w-1:0] cnd_ltu    = 3'd6;
	localparam logic [cnd_w-1:0] cnd_geu    = 3'd7;

	// --------------------
	// mux bus bit positions
	// --------------------
	localparam int mux_w = 5;

	// operand a: pc, else bypassed src1
	localparam int mux_a_pc      = 0;
	// operand b: immediate, else bypassed src2
	localparam int mux_b_imm     = 1;
	// address base pc, wins over src1
	localparam int mux_base_pc   = 2;
	// address base src1, both low means pc_4
	localparam int mux_base_src1 = 3;
	// writeback from memory data, else alu result
	localparam int mux_alu_mem   = 4;

	// --------------------
	// writeback extension, carried only
	// --------------------
	localparam int wb_sx_w = 3;

	localparam logic [wb_sx_w-1:0] wb_sx_byte = 3'd0;
	localparam logic [wb_sx_w-1:0] wb_sx_half = 3'd1;
	localparam logic [wb_sx_w-1:0] wb_sx_word = 3'd2;
	localparam logic [wb_sx_w-1:0] wb_zx_byte = 3'd3;
	localparam logic [wb_sx_w-1:0] wb_zx_half = 3'd4;
	localparam logic [wb_sx_w-1:0] wb_sx_bp   = 3'd5;

	// data cache access size
	localparam int l1d_size_w = 3;

endpackage

// ==== src/core_exe_operand.sv ====
// operand side of execute: bypass selection, alu operand muxes, target address adder
module core_exe_operand (
	input  logic [31:0]                     src1,
	input  logic [31:0]                     src2,
	input  logic [31:0]                     pc,
	input  logic [31:0]                     pc_4,
	input  logic [31:0]                     sx_imm,
	input  logic [31:0]                     result_m,
	input  logic [31:0]                     result_w,
	input  logic [core_byp_pkg::byp_w-1:0]  byp_src1,
	input  logic [core_byp_pkg::byp_w-1:0]  byp_src2,
	input  logic [core_ctrl_pkg::mux_w-1:0] mux_bus,
	output logic [31:0]                     alu_a,
	output logic [31:0]                     alu_b,
	output logic [31:0]                     addr,
	output logic [31:0]                     store_data
);

	// bypassed sources
	logic [31:0] src1_byp;
	logic [31:0] src2_byp;
	// selected address base
	logic [31:0] addr_base;

	// one bypass mux, shared by both sources
	function automatic logic [31:0] pick_src(
		input logic [core_byp_pkg::byp_w-1:0] sel,
		input logic [31:0]                    rf_val,
		input logic [31:0]                    mem_val,
		input logic [31:0]                    wb_val
	);
		logic [31:0] val;
		case (sel)
			core_byp_pkg::byp_mem: val = mem_val;
			core_byp_pkg::byp_wb:  val = wb_val;
			// byp_rf and the illegal code fall back to the file value
			default:               val = rf_val;
		endcase
		return val;
	endfunction

	// --------------------
	// forwarding
	// --------------------
	assign src1_byp = pick_src(byp_src1, src1, result_m, result_w);
	// second operand forwards from src2
	assign src2_byp = pick_src(byp_src2, src2, result_m, result_w);

	// --------------------
	// alu operands
	// --------------------
	// auipc / jal take pc as a
	assign alu_a = mux_bus[core_ctrl_pkg::mux_a_pc] ? pc : src1_byp;
	// i-type and lui take the immediate as b
	assign alu_b = mux_bus[core_ctrl_pkg::mux_b_imm] ? sx_imm : src2_byp;

	// --------------------
	// target address
	// --------------------
	// pc wins, then src1, else pc_4
	assign addr_base = mux_bus[core_ctrl_pkg::mux_base_pc]   ? pc :
	                   mux_bus[core_ctrl_pkg::mux_base_src1] ? src1_byp : pc_4;
	assign addr = addr_base + sx_imm;

	// store data follows the src2 bypass
	assign store_data = src2_byp;

	// decode never issues bypass code 3
	always_comb begin
		assert final (byp_src1 !== 2'b11 && byp_src2 !== 2'b11)
			else $error("illegal bypass select src1=%0d src2=%0d", byp_src1, byp_src2);
	end

endmodule

// ==== src/core_exe_reg.sv ====
// execute/memory pipeline register with enable, kill and reset of the control bits
module core_exe_reg (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 enb,
	input  logic                                 kill,
	// control from decode
	input  logic                                 val_inst,
	input  logic                                 we_reg_file,
	input  logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op,
	input  logic [core_ctrl_pkg::mux_w-1:0]      mux_bus,
	input  logic                                 l1d_val,
	input  logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size,
	input  logic                                 l1d_cop,
	input  logic                                 mux_trn,
	// payload
	input  logic [31:0]                          alu_result,
	input  logic [31:0]                          addr,
	input  logic [31:0]                          store_data,
	input  logic [31:0]                          sx_imm,
	input  logic [31:0]                          pc_4,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rs1,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rs2,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rd,
	input  logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd,
	// registered outputs
	output logic                                 val_inst_q,
	output logic                                 we_reg_file_q,
	output logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op_q,
	output logic                                 mux_alu_mem_q,
	output logic                                 l1d_val_q,
	output logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size_q,
	output logic                                 l1d_cop_q,
	output logic                                 mux_trn_q,
	output logic [31:0]                          alu_result_q,
	output logic [31:0]                          addr_q,
	output logic [31:0]                          store_data_q,
	output logic [31:0]                          sx_imm_q,
	output logic [31:0]                          pc_4_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rs1_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rs2_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rd_q,
	output logic [core_byp_pkg::haz_cmd_w-1:0]  haz_cmd_q
);

	// --------------------
	// side-effect bits
	// --------------------
	// kill turns the slot into a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			val_inst_q    <= 1'b0;
			we_reg_file_q <= 1'b0;
			l1d_val_q     <= 1'b0;
		end else if (enb) begin
			val_inst_q    <= val_inst && !kill;
			we_reg_file_q <= we_reg_file && !kill;
			l1d_val_q     <= l1d_val && !kill;
		end
	end

	// --------------------
	// payload, enable only
	// --------------------
	always_ff @(posedge clk) begin
		if (enb) begin
			wb_sx_op_q    <= wb_sx_op;
			// only the writeback source bit goes on
			mux_alu_mem_q <= mux_bus[core_ctrl_pkg::mux_alu_mem];
			l1d_size_q    <= l1d_size;
			l1d_cop_q     <= l1d_cop;
			mux_trn_q     <= mux_trn;
			alu_result_q  <= alu_result;
			addr_q        <= addr;
			store_data_q  <= store_data;
			sx_imm_q      <= sx_imm;
			pc_4_q        <= pc_4;
			rs1_q         <= rs1;
			rs2_q         <= rs2;
			rd_q          <= rd;
			haz_cmd_q     <= haz_cmd;
		end
	end

	// a killed slot must never reach the data cache
	assert property (@(posedge clk) disable iff (!rst_n) (enb && kill) |=> !l1d_val_q)
		else $error("killed instruction left l1d_val_q high");

endmodule

// ==== src/core_exe_s.sv ====
// execute stage top: operand, alu and stage register instances plus hazard unit taps
module core_exe_s (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// from hazard unit
	input  logic                                 enb,
	input  logic                                 kill,
	input  logic [core_byp_pkg::byp_w-1:0]       byp_src1,
	input  logic [core_byp_pkg::byp_w-1:0]       byp_src2,
	// from decode, control
	input  logic                                 val_inst,
	input  logic                                 we_reg_file,
	input  logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op,
	input  logic [core_ctrl_pkg::mux_w-1:0]      mux_bus,
	input  logic [core_ctrl_pkg::alu_op_w-1:0]   alu_op,
	input  logic [core_ctrl_pkg::cnd_w-1:0]      alu_cnd,
	input  logic                                 l1d_val,
	input  logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size,
	input  logic                                 l1d_cop,
	input  logic                                 mux_trn,
	// from decode, data
	input  logic [31:0]                          src1,
	input  logic [31:0]                          src2,
	input  logic [31:0]                          pc,
	input  logic [31:0]                          pc_4,
	input  logic [31:0]                          sx_imm,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rs1,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rs2,
	input  logic [core_byp_pkg::reg_idx_w-1:0]   rd,
	input  logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd,
	// forwarded results
	input  logic [31:0]                          result_m,
	input  logic [31:0]                          result_w,
	// to memory stage
	output logic                                 val_inst_q,
	output logic                                 we_reg_file_q,
	output logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op_q,
	output logic                                 mux_alu_mem_q,
	output logic                                 l1d_val_q,
	output logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size_q,
	output logic                                 l1d_cop_q,
	output logic                                 mux_trn_q,
	output logic [31:0]                          alu_result_q,
	output logic [31:0]                          addr_q,
	output logic [31:0]                          store_data_q,
	output logic [31:0]                          sx_imm_q,
	output logic [31:0]                          pc_4_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rs1_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rs2_q,
	output logic [core_byp_pkg::reg_idx_w-1:0]   rd_q,
	output logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd_q,
	// combinational taps to hazard unit
	output logic                                 branch_taken,
	output logic                                 haz_we_reg_file,
	output logic [core_byp_pkg::reg_idx_w-1:0]   haz_rs1,
	output logic [core_byp_pkg::reg_idx_w-1:0]   haz_rs2,
	output logic [core_byp_pkg::reg_idx_w-1:0]   haz_rd,
	output logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd_out
);

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] addr;
	logic [31:0] store_data;
	logic [31:0] alu_result;

	core_exe_operand operand_i (
		.src1, .src2, .pc, .pc_4, .sx_imm, .result_m, .result_w,
		.byp_src1, .byp_src2, .mux_bus,
		.alu_a, .alu_b, .addr, .store_data
	);

	core_alu alu_i (
		.alu_a, .alu_b, .alu_op, .alu_cnd, .alu_result, .branch_taken
	);

	core_exe_reg reg_i (
		.clk, .rst_n, .enb, .kill,
		.val_inst, .we_reg_file, .wb_sx_op, .mux_bus, .l1d_val, .l1d_size, .l1d_cop, .mux_trn,
		.alu_result, .addr, .store_data, .sx_imm, .pc_4, .rs1, .rs2, .rd, .haz_cmd,
		.val_inst_q, .we_reg_file_q, .wb_sx_op_q, .mux_alu_mem_q, .l1d_val_q, .l1d_size_q,
		.l1d_cop_q, .mux_trn_q, .alu_result_q, .addr_q, .store_data_q, .sx_imm_q, .pc_4_q,
		.rs1_q, .rs2_q, .rd_q, .haz_cmd_q
	);

	// hazard taps see the instruction now in execute
	assign haz_we_reg_file = we_reg_file;
	assign haz_rs1         = rs1;
	assign haz_rs2         = rs2;
	assign haz_rd          = rd;
	assign haz_cmd_out     = haz_cmd;

endmodule

// ==== testbench/tb_core_exe_s.sv ====
// directed testbench for the execute stage: reference model, lfsr operands, watchdog
module tb_core_exe_s;

	// --------------------
	// dut signals
	// --------------------
	logic clk;
	logic rst_n;
	logic enb, kill, val_inst, we_reg_file, l1d_val, l1d_cop, mux_trn;
	logic [core_byp_pkg::byp_w-1:0]       byp_src1, byp_src2;
	logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op;
	logic [core_ctrl_pkg::mux_w-1:0]      mux_bus;
	logic [core_ctrl_pkg::alu_op_w-1:0]   alu_op;
	logic [core_ctrl_pkg::cnd_w-1:0]      alu_cnd;
	logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size;
	logic [31:0]                          src1, src2, pc, pc_4, sx_imm, result_m, result_w;
	logic [core_byp_pkg::reg_idx_w-1:0]   rs1, rs2, rd;
	logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd;
	// stage register and hazard taps
	logic val_inst_q, we_reg_file_q, mux_alu_mem_q, l1d_val_q, l1d_cop_q, mux_trn_q;
	logic [core_ctrl_pkg::wb_sx_w-1:0]    wb_sx_op_q;
	logic [core_ctrl_pkg::l1d_size_w-1:0] l1d_size_q;
	logic [31:0]                          alu_result_q, addr_q, store_data_q, sx_imm_q, pc_4_q;
	logic [core_byp_pkg::reg_idx_w-1:0]   rs1_q, rs2_q, rd_q, haz_rs1, haz_rs2, haz_rd;
	logic [core_byp_pkg::haz_cmd_w-1:0]   haz_cmd_q, haz_cmd_out;
	logic                                 branch_taken, haz_we_reg_file;

	// bookkeeping
	int          checks;
	int          errors;
	int          tests_run;
	logic [15:0] lfsr_state;

	// --------------------
	// run length
	// --------------------
	localparam int period        = 8;
	// two cycles per registered transaction, one per combinational one
	localparam int alu_cycles    = 11 * 3 * 2;
	localparam int branch_cycles = 8 * 3;
	localparam int bypass_cycles = 9 * 2 * 2;
	localparam int mux_cycles    = 1 + 8 * 2;
	localparam int stall_cycles  = 12;
	localparam int reset_cycles  = 8;
	localparam int run_cycles    = 4 + alu_cycles + branch_cycles + bypass_cycles +
	                               mux_cycles + stall_cycles + reset_cycles;
	// double length as margin
	localparam int watchdog_time = 2 * run_cycles * period;

	core_exe_s dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	// 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// rv32i result from the instruction set rules
	function automatic logic [31:0] alu_expect(input logic [core_ctrl_pkg::alu_op_w-1:0] op,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic        lt_s;
		logic [31:0] r;
		sh = b[4:0];
		// differing signs decide alone
		lt_s = (a[31] != b[31]) ? a[31] : (a < b);
		case (op)
			core_ctrl_pkg::alu_add:    r = a + b;
			core_ctrl_pkg::alu_sub:    r = a + ~b + 32'd1;
			core_ctrl_pkg::alu_sll:    r = a << sh;
			core_ctrl_pkg::alu_slt:    r = {31'd0, lt_s};
			core_ctrl_pkg::alu_sltu:   r = (a < b) ? 32'd1 : 32'd0;
			core_ctrl_pkg::alu_xor:    r = a ^ b;
			core_ctrl_pkg::alu_srl:    r = a >> sh;
			// logical shift, then sign into the vacated top bits
			core_ctrl_pkg::alu_sra:    r = (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
			core_ctrl_pkg::alu_or:     r = a | b;
			core_ctrl_pkg::alu_and:    r = a & b;
			core_ctrl_pkg::alu_pass_b: r = b;
			default:                   r = '0;
		endcase
		return r;
	endfunction

	// branch decision per condition code
	function automatic logic branch_expect(input logic [core_ctrl_pkg::cnd_w-1:0] cnd,
			input logic [31:0] a, input logic [31:0] b);
		logic lt_s;
		logic t;
		lt_s = (a[31] != b[31]) ? a[31] : (a < b);
		case (cnd)
			core_ctrl_pkg::cnd_never:  t = 1'b0;
			core_ctrl_pkg::cnd_always: t = 1'b1;
			core_ctrl_pkg::cnd_eq:     t = (a == b);
			core_ctrl_pkg::cnd_ne:     t = (a != b);
			core_ctrl_pkg::cnd_lt:     t = lt_s;
			core_ctrl_pkg::cnd_ge:     t = !lt_s;
			core_ctrl_pkg::cnd_ltu:    t = (a < b);
			default:                   t = (a >= b);
		endcase
		return t;
	endfunction

	// value a bypass select should deliver
	function automatic logic [31:0] forwarded(input logic [core_byp_pkg::byp_w-1:0] sel,
			input logic [31:0] rf_v, input logic [31:0] m_v, input logic [31:0] w_v);
		if (sel == core_byp_pkg::byp_mem)
			return m_v;
		if (sel == core_byp_pkg::byp_wb)
			return w_v;
		return rf_v;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic end_of_test(input string name, input int err_start);
		tests_run++;
		$display("test %s %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
		         errors - err_start);
	endtask

	// quiet inputs, called right after a rising edge
	task automatic idle_inputs();
		{enb, kill} <= 2'b10;
		{val_inst, we_reg_file, l1d_val, l1d_cop, mux_trn} <= '0;
		{byp_src1, byp_src2, mux_bus, alu_op, alu_cnd} <= '0;
		{wb_sx_op, l1d_size, haz_cmd, rs1, rs2, rd} <= '0;
		{src1, src2, pc, pc_4, sx_imm, result_m, result_w} <= '0;
	endtask

	// register contents are stable at the falling edge after the load
	task automatic wait_load();
		@(negedge clk);
		@(negedge clk);
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic alu_ops_check();
		int          err_start;
		logic [31:0] a, b;
		err_start = errors;
		for (int op = 0; op <= 10; op++) begin
			repeat (3) begin
				a = rand_bits(32);
				b = rand_bits(32);
				@(posedge clk);
				idle_inputs();
				alu_op <= op[3:0];
				{src1, src2} <= {a, b};
				wait_load();
				compare_word("alu_ops", alu_expect(op[3:0], a, b), alu_result_q);
			end
		end
		end_of_test("alu_ops", err_start);
	endtask

	task automatic branch_conditions();
		int          err_start;
		logic [31:0] a [3];
		logic [31:0] b [3];
		err_start = errors;
		// equal, signed less, unsigned less
		a[0] = rand_bits(32);
		b[0] = a[0];
		a[1] = rand_bits(31) | 32'h8000_0000;
		b[1] = rand_bits(31);
		a[2] = rand_bits(31);
		b[2] = rand_bits(31) | 32'h8000_0000;
		for (int c = 0; c < 8; c++) begin
			for (int p = 0; p < 3; p++) begin
				@(posedge clk);
				idle_inputs();
				alu_cnd <= c[2:0];
				{src1, src2} <= {a[p], b[p]};
				@(negedge clk);
				compare_word("branches", branch_expect(c[2:0], a[p], b[p]), branch_taken);
			end
		end
		end_of_test("branches", err_start);
	endtask

	task automatic bypass_paths();
		int          err_start;
		logic [31:0] s1, s2, rm, rw, x, y;
		err_start = errors;
		// top nibble keeps the four sources apart
		s1 = 32'h1000_0000 | rand_bits(28);
		s2 = 32'h2000_0000 | rand_bits(28);
		rm = 32'h3000_0000 | rand_bits(28);
		rw = 32'h4000_0000 | rand_bits(28);
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				x = forwarded(i[1:0], s1, rm, rw);
				y = forwarded(j[1:0], s2, rm, rw);
				// add first, then pass_b
				for (int k = 0; k < 2; k++) begin
					@(posedge clk);
					idle_inputs();
					alu_op <= k ? core_ctrl_pkg::alu_pass_b : core_ctrl_pkg::alu_add;
					{byp_src1, byp_src2} <= {i[1:0], j[1:0]};
					{src1, src2, result_m, result_w} <= {s1, s2, rm, rw};
					wait_load();
					compare_word("bypass", k ? y : x + y, alu_result_q);
					compare_word("bypass", y, store_data_q);
				end
			end
		end
		end_of_test("bypass", err_start);
	endtask

	// one mux bus setting against data already at the inputs
	task automatic mux_case(input logic [core_ctrl_pkg::mux_w-1:0] bus,
			input logic [core_ctrl_pkg::alu_op_w-1:0] op,
			input logic [core_byp_pkg::byp_w-1:0] sel1,
			input logic [31:0] exp_addr, input logic [31:0] exp_result);
		@(posedge clk);
		mux_bus <= bus;
		alu_op <= op;
		byp_src1 <= sel1;
		wait_load();
		compare_word("muxes", exp_addr, addr_q);
		compare_word("muxes", exp_result, alu_result_q);
		compare_word("muxes", bus[core_ctrl_pkg::mux_alu_mem], mux_alu_mem_q);
	endtask

	task automatic address_muxes();
		int                             err_start;
		logic [31:0]                    pcv, s1, s2, imm, rm;
		logic [core_ctrl_pkg::mux_w-1:0] b_apc, b_bimm, b_pc, b_src1, b_mem;
		err_start = errors;
		b_apc  = 5'd1 << core_ctrl_pkg::mux_a_pc;
		b_bimm = 5'd1 << core_ctrl_pkg::mux_b_imm;
		b_pc   = 5'd1 << core_ctrl_pkg::mux_base_pc;
		b_src1 = 5'd1 << core_ctrl_pkg::mux_base_src1;
		b_mem  = 5'd1 << core_ctrl_pkg::mux_alu_mem;
		pcv = rand_bits(32) & ~32'd3;
		s1  = rand_bits(32);
		s2  = rand_bits(32);
		imm = rand_bits(32);
		rm  = rand_bits(32);
		@(posedge clk);
		idle_inputs();
		{src1, src2, pc, pc_4, sx_imm, result_m} <= {s1, s2, pcv, pcv + 32'd4, imm, rm};
		mux_case(b_pc, core_ctrl_pkg::alu_add, core_byp_pkg::byp_rf, pcv + imm, s1 + s2);
		mux_case(b_src1, core_ctrl_pkg::alu_add, core_byp_pkg::byp_rf, s1 + imm, s1 + s2);
		// pc base wins over src1
		mux_case(b_pc | b_src1, core_ctrl_pkg::alu_add, core_byp_pkg::byp_rf, pcv + imm, s1 + s2);
		mux_case(b_mem, core_ctrl_pkg::alu_add, core_byp_pkg::byp_rf, pcv + 32'd4 + imm, s1 + s2);
		// jalr base through the bypass
		mux_case(b_src1, core_ctrl_pkg::alu_add, core_byp_pkg::byp_mem, rm + imm, rm + s2);
		mux_case(b_apc, core_ctrl_pkg::alu_sub, core_byp_pkg::byp_rf, pcv + 32'd4 + imm, pcv - s2);
		mux_case(b_bimm, core_ctrl_pkg::alu_pass_b, core_byp_pkg::byp_rf, pcv + 32'd4 + imm, imm);
		// auipc
		mux_case(b_apc | b_bimm, core_ctrl_pkg::alu_add, core_byp_pkg::byp_rf,
		         pcv + 32'd4 + imm, pcv + imm);
		// immediate and pc_4 ride along unchanged
		compare_word("muxes", imm, sx_imm_q);
		compare_word("muxes", pcv + 32'd4, pc_4_q);
		end_of_test("muxes", err_start);
	endtask

	task automatic stall_and_kill();
		int          err_start;
		logic [31:0] a, b, imm;
		err_start = errors;
		a   = rand_bits(32);
		b   = rand_bits(32);
		imm = rand_bits(32);
		// a live store-like instruction
		@(posedge clk);
		idle_inputs();
		{val_inst, we_reg_file, l1d_val} <= 3'b111;
		{src1, src2, sx_imm} <= {a, b, imm};
		mux_bus <= 5'd1 << core_ctrl_pkg::mux_base_src1;
		rd <= 5'd9;
		wait_load();
		// stall with other values at the inputs
		@(posedge clk);
		idle_inputs();
		enb <= 1'b0;
		{src1, src2, sx_imm} <= {~a, ~b, ~imm};
		rd <= 5'd17;
		repeat (3) @(negedge clk);
		compare_word("stall", 1'b1, val_inst_q);
		compare_word("stall", 1'b1, we_reg_file_q);
		compare_word("stall", 1'b1, l1d_val_q);
		compare_word("stall", 5'd9, rd_q);
		compare_word("stall", a + b, alu_result_q);
		compare_word("stall", a + imm, addr_q);
		compare_word("stall", b, store_data_q);
		// kill drops the side-effect bits only
		@(posedge clk);
		idle_inputs();
		kill <= 1'b1;
		{val_inst, we_reg_file, l1d_val} <= 3'b111;
		{src1, src2, sx_imm} <= {b, a, imm};
		mux_bus <= 5'd1 << core_ctrl_pkg::mux_base_src1;
		rd <= 5'd21;
		wait_load();
		compare_word("kill", 1'b0, val_inst_q);
		compare_word("kill", 1'b0, we_reg_file_q);
		compare_word("kill", 1'b0, l1d_val_q);
		compare_word("kill", 5'd21, rd_q);
		compare_word("kill", b + imm, addr_q);
		// next instruction goes through again
		@(posedge clk);
		idle_inputs();
		val_inst <= 1'b1;
		wait_load();
		compare_word("kill", 1'b1, val_inst_q);
		end_of_test("stall_kill", err_start);
	endtask

	task automatic reset_passthrough();
		int                                   err_start;
		logic [core_ctrl_pkg::wb_sx_w-1:0]    wb;
		logic [core_ctrl_pkg::l1d_size_w-1:0] sz;
		logic [core_byp_pkg::reg_idx_w-1:0]   r1, r2, rdv;
		err_start = errors;
		wb  = rand_bits(3);
		sz  = rand_bits(3);
		r1  = rand_bits(5);
		r2  = rand_bits(5);
		rdv = rand_bits(5);
		// reset with a live instruction at the inputs
		@(posedge clk);
		idle_inputs();
		{val_inst, we_reg_file, l1d_val} <= 3'b111;
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare_word("reset", 1'b0, val_inst_q);
		compare_word("reset", 1'b0, we_reg_file_q);
		compare_word("reset", 1'b0, l1d_val_q);
		@(posedge clk);
		rst_n <= 1'b1;
		idle_inputs();
		{val_inst, we_reg_file, l1d_cop, mux_trn} <= 4'b1111;
		{wb_sx_op, l1d_size, haz_cmd} <= {wb, sz, core_byp_pkg::haz_branch};
		{rs1, rs2, rd} <= {r1, r2, rdv};
		// taps follow the inputs in the same cycle
		@(negedge clk);
		compare_word("taps", 1'b1, haz_we_reg_file);
		compare_word("taps", r1, haz_rs1);
		compare_word("taps", r2, haz_rs2);
		compare_word("taps", rdv, haz_rd);
		compare_word("taps", core_byp_pkg::haz_branch, haz_cmd_out);
		@(negedge clk);
		compare_word("passthrough", 1'b1, val_inst_q);
		compare_word("passthrough", wb, wb_sx_op_q);
		compare_word("passthrough", sz, l1d_size_q);
		compare_word("passthrough", 1'b1, l1d_cop_q);
		compare_word("passthrough", 1'b1, mux_trn_q);
		compare_word("passthrough", {r1, r2, rdv}, {rs1_q, rs2_q, rd_q});
		compare_word("passthrough", core_byp_pkg::haz_branch, haz_cmd_q);
		end_of_test("reset_pass", err_start);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		checks = 0;
		errors = 0;
		tests_run = 0;
		lfsr_state = 16'd67;
		rst_n <= 1'b0;
		idle_inputs();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		alu_ops_check();
		branch_conditions();
		bypass_paths();
		address_muxes();
		stall_and_kill();
		reset_passthrough();
		@(negedge clk);
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(watchdog_time);
		$display("watchdog: the run did not end within %0d time units", watchdog_time);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
